//--- source/cachePkg.sv
package cachePkg;

    // cpu request kinds
    typedef enum logic [1:0] {
        opRead       = 2'd0,
        opWrite      = 2'd1,
        opInvalidate = 2'd2
    } cacheOp_t;

    // controller states
    typedef enum logic [2:0] {
        Idle      = 3'd0,
        Lookup    = 3'd1,   // tag compare on the buffered request
        MissRead  = 3'd2,   // line request held until addrOk
        MissWait  = 3'd3,   // waiting for the line
        Replace   = 3'd4,   // bubble after refill
        MemWrite  = 3'd5,   // write-through to memory
        Operation = 3'd6    // set invalidate
    } cacheState_t;

    ////////////////////////////////////////
    // fixed sizes
    ////////////////////////////////////////

    localparam int WAYS   = 2;           // one-bit LRU needs exactly two
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // one strobe per byte

endpackage

//--- source/wayCtrlIf.sv
`timescale 1ns/1ps

interface wayCtrlIf;
    import cachePkg::*;

    logic [WAYS-1:0] hit;            // per-way tag match, meaningful in Lookup
    logic [WAYS-1:0] wayWe;          // one way at a time
    logic            fillLine;       // store memory line and set valid
    logic            writeWord;      // strobe merge into the buffered word
    logic            invalidateSet;  // clear valid in both ways
    logic            readWay;        // way feeding the response
    logic            forwardFill;    // response taken from memory line

    // controller side
    modport ctrl (
        input  hit,
        output wayWe, fillLine, writeWord, invalidateSet, readWay, forwardFill
    );

    // array side
    modport ways (
        output hit,
        input  wayWe, fillLine, writeWord, invalidateSet, readWay, forwardFill
    );

endinterface

//--- source/lruTable.sv
`timescale 1ns/1ps

module lruTable #(
    parameter int indexWidth = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [indexWidth-1:0] bufIndex,
    input  logic                  touch,
    input  logic                  touchWay,   // way just used
    output logic                  victim
);
    localparam int sets = 2 ** indexWidth;

    // one bit per set naming the older way
    logic [sets-1:0] lruBits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lruBits <= '0;
        end else if (touch) begin
            lruBits[bufIndex] <= ~touchWay;  // the other way is now oldest
        end
    end

    assign victim = lruBits[bufIndex];

endmodule

//--- source/cacheWays.sv
`timescale 1ns/1ps

module cacheWays #(
    parameter int indexWidth  = 4,
    parameter int offsetWidth = 2
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [indexWidth-1:0]                        bufIndex,
    input  logic [29-indexWidth-offsetWidth:0]           bufTag,
    input  logic [offsetWidth-1:0]                       bufWord,
    input  logic [cachePkg::DATA_W-1:0]                  bufWdata,
    input  logic [cachePkg::STRB_W-1:0]                  bufWstrb,
    input  logic [cachePkg::DATA_W*(2**offsetWidth)-1:0] memRdata,
    output logic [cachePkg::DATA_W-1:0]                  respData,
    wayCtrlIf.ways                                       wc
);
    import cachePkg::*;

    localparam int tagWidth  = 30 - indexWidth - offsetWidth;
    localparam int sets      = 2 ** indexWidth;
    localparam int lineWidth = DATA_W * (2 ** offsetWidth);

    logic [tagWidth-1:0]  tagArr   [WAYS][sets];
    logic [lineWidth-1:0] dataArr  [WAYS][sets];
    logic [sets-1:0]      validArr [WAYS];
    logic [lineWidth-1:0] readLine;

    ////////////////////////////////////////
    // hit compare
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            wc.hit[w] = validArr[w][bufIndex] && (tagArr[w][bufIndex] == bufTag);
        end
    end

    ////////////////////////////////////////
    // array updates
    ////////////////////////////////////////

    // invalidate wins over a fill
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < WAYS; w++) begin
                validArr[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (wc.invalidateSet) begin
                    validArr[w][bufIndex] <= 1'b0;
                end else if (wc.wayWe[w] && wc.fillLine) begin
                    validArr[w][bufIndex] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wc.wayWe[w] && wc.fillLine) begin
                tagArr[w][bufIndex]  <= bufTag;
                dataArr[w][bufIndex] <= memRdata;   // whole line at once
            end else if (wc.wayWe[w] && wc.writeWord) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (bufWstrb[b]) begin
                        dataArr[w][bufIndex][bufWord * DATA_W + b * 8 +: 8]
                            <= bufWdata[b * 8 +: 8];
                    end
                end
            end
        end
    end

    // refill data bypasses the arrays
    assign readLine = wc.forwardFill ? memRdata : dataArr[wc.readWay][bufIndex];
    assign respData = readLine[bufWord * DATA_W +: DATA_W];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rstn) $onehot0(wc.wayWe))
        else $error("more than one way written");

    // fills only go to a missing line so a tag lives in one way
    assert property (@(posedge clk) disable iff (!rstn) !(&wc.hit))
        else $error("same tag hit in both ways");

endmodule

//--- source/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl #(
    parameter int indexWidth  = 4,
    parameter int offsetWidth = 2
) (
    input  logic                               clk,
    input  logic                               rstn,
    // cpu side
    input  logic                               cpuValid,
    output logic                               cpuReady,
    input  cachePkg::cacheOp_t                 cpuOp,
    input  logic [31:0]                        cpuAddr,
    input  logic [cachePkg::DATA_W-1:0]        cpuWdata,
    input  logic [cachePkg::STRB_W-1:0]        cpuWstrb,
    output logic                               respValid,
    // memory side
    output logic                               memReq,
    output logic                               memWr,
    output logic [31:0]                        memAddr,
    output logic [cachePkg::DATA_W-1:0]        memWdata,
    output logic [cachePkg::STRB_W-1:0]        memWstrb,
    input  logic                               memAddrOk,
    input  logic                               memDataOk,
    // buffered request
    output logic [indexWidth-1:0]              bufIndex,
    output logic [29-indexWidth-offsetWidth:0] bufTag,
    output logic [offsetWidth-1:0]             bufWord,
    output logic [cachePkg::DATA_W-1:0]        bufWdata,
    output logic [cachePkg::STRB_W-1:0]        bufWstrb,
    // lru
    output logic                               touch,
    output logic                               touchWay,
    input  logic                               victim,
    wayCtrlIf.ctrl                             wc
);
    import cachePkg::*;

    localparam int tagWidth = 30 - indexWidth - offsetWidth;

    cacheState_t state;
    cacheState_t nextState;
    cacheOp_t    bufOp;
    logic        bufLoad;
    logic        holdReq;   // request taken in the dataOk cycle
    logic        anyHit;
    logic        hitWay;
    logic [31:0] lineAddr;
    logic [31:0] wordAddr;

    assign bufLoad  = cpuValid && cpuReady;
    assign anyHit   = |wc.hit;
    assign hitWay   = wc.hit[1];
    assign lineAddr = {bufTag, bufIndex, {offsetWidth{1'b0}}, 2'b00};  // refill start
    assign wordAddr = {bufTag, bufIndex, bufWord, 2'b00};

    ////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bufLoad) begin
            bufOp    <= cpuOp;
            bufTag   <= cpuAddr[31 -: tagWidth];
            bufIndex <= cpuAddr[2 + offsetWidth +: indexWidth];
            bufWord  <= cpuAddr[2 +: offsetWidth];
            bufWdata <= cpuWdata;
            bufWstrb <= cpuWstrb;
        end
    end

    ////////////////////////////////////////
    // state register and next state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= Idle;
            holdReq <= 1'b0;
        end else begin
            state   <= nextState;
            holdReq <= (state == MissWait) && bufLoad;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                nextState = cpuValid ? Lookup : Idle;
            end
            Lookup: begin
                if (bufOp == opInvalidate) begin
                    nextState = Operation;
                end else if (bufOp == opWrite) begin
                    nextState = MemWrite;
                end else if (!anyHit) begin
                    nextState = memAddrOk ? MissWait : MissRead;
                end else begin
                    nextState = cpuValid ? Lookup : Idle;  // hit keeps streaming
                end
            end
            MissRead: begin
                if (memAddrOk) begin
                    nextState = MissWait;
                end
            end
            MissWait: begin
                if (memDataOk) begin
                    nextState = Replace;
                end
            end
            Replace: begin
                nextState = holdReq ? Lookup : Idle;
            end
            MemWrite: begin
                if (memAddrOk) begin
                    nextState = cpuValid ? Lookup : Idle;
                end
            end
            Operation: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    ////////////////////////////////////////
    // outputs per state and next state
    ////////////////////////////////////////

    always_comb begin
        cpuReady         = 1'b0;
        respValid        = 1'b0;
        memReq           = 1'b0;
        memWr            = 1'b0;
        memAddr          = lineAddr;
        memWdata         = bufWdata;
        memWstrb         = '0;
        touch            = 1'b0;
        touchWay         = hitWay;
        wc.wayWe         = '0;
        wc.fillLine      = 1'b0;
        wc.writeWord     = 1'b0;
        wc.invalidateSet = 1'b0;
        wc.readWay       = hitWay;
        wc.forwardFill   = 1'b0;
        case (state)
            Idle: begin
                cpuReady = 1'b1;
            end
            Lookup: begin
                case (nextState)
                    MissRead, MissWait: begin
                        memReq = 1'b1;  // read miss asks for the line
                    end
                    MemWrite: begin
                        if (anyHit) begin   // write hit also updates the word
                            wc.wayWe[hitWay] = 1'b1;
                            wc.writeWord     = 1'b1;
                            touch            = 1'b1;
                        end
                    end
                    Lookup, Idle: begin
                        cpuReady  = 1'b1;
                        respValid = 1'b1;
                        touch     = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            MissRead: begin
                memReq = 1'b1;
            end
            MissWait: begin
                if (nextState == Replace) begin
                    // forward the word and fill the victim
                    cpuReady         = 1'b1;
                    respValid        = 1'b1;
                    wc.forwardFill   = 1'b1;
                    wc.fillLine      = 1'b1;
                    wc.wayWe[victim] = 1'b1;
                    touch            = 1'b1;
                    touchWay         = victim;
                end
            end
            MemWrite: begin
                memReq   = 1'b1;
                memWr    = 1'b1;
                memAddr  = wordAddr;
                memWstrb = bufWstrb;
                if (nextState != MemWrite) begin
                    cpuReady = 1'b1;  // addrOk cycle
                end
            end
            Operation: begin
                wc.invalidateSet = 1'b1;
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // memory request must sit still until it is taken
    property memReqHeld;
        @(posedge clk) disable iff (!rstn)
        memReq && !memAddrOk |=> memReq && $stable(memAddr) && $stable(memWr);
    endproperty

    assert property (memReqHeld)
        else $error("memory request changed before addrOk");

    assert property (@(posedge clk) disable iff (!rstn) state == Idle |-> !respValid)
        else $error("response raised in Idle");

endmodule

//--- source/cacheTop.sv
`timescale 1ns/1ps

module cacheTop #(
    parameter int indexWidth  = 4,
    parameter int offsetWidth = 2
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    // cpu side
    input  logic                                         cpuValid,
    output logic                                         cpuReady,
    input  cachePkg::cacheOp_t                           cpuOp,
    input  logic [31:0]                                  cpuAddr,
    input  logic [cachePkg::DATA_W-1:0]                  cpuWdata,
    input  logic [cachePkg::STRB_W-1:0]                  cpuWstrb,
    output logic                                         respValid,
    output logic [cachePkg::DATA_W-1:0]                  respData,
    // memory side
    output logic                                         memReq,
    output logic                                         memWr,
    output logic [31:0]                                  memAddr,
    output logic [cachePkg::DATA_W-1:0]                  memWdata,
    output logic [cachePkg::STRB_W-1:0]                  memWstrb,
    input  logic                                         memAddrOk,
    input  logic                                         memDataOk,
    input  logic [cachePkg::DATA_W*(2**offsetWidth)-1:0] memRdata
);
    import cachePkg::*;

    localparam int tagWidth = 30 - indexWidth - offsetWidth;

    // buffered request fanned out to arrays and lru
    logic [indexWidth-1:0]  bufIndex;
    logic [tagWidth-1:0]    bufTag;
    logic [offsetWidth-1:0] bufWord;
    logic [DATA_W-1:0]      bufWdata;
    logic [STRB_W-1:0]      bufWstrb;
    logic                   touch;
    logic                   touchWay;
    logic                   victim;

    wayCtrlIf wc ();

    cacheCtrl #(
        .indexWidth  (indexWidth),
        .offsetWidth (offsetWidth)
    ) u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .cpuValid  (cpuValid),
        .cpuReady  (cpuReady),
        .cpuOp     (cpuOp),
        .cpuAddr   (cpuAddr),
        .cpuWdata  (cpuWdata),
        .cpuWstrb  (cpuWstrb),
        .respValid (respValid),
        .memReq    (memReq),
        .memWr     (memWr),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memWstrb  (memWstrb),
        .memAddrOk (memAddrOk),
        .memDataOk (memDataOk),
        .bufIndex  (bufIndex),
        .bufTag    (bufTag),
        .bufWord   (bufWord),
        .bufWdata  (bufWdata),
        .bufWstrb  (bufWstrb),
        .touch     (touch),
        .touchWay  (touchWay),
        .victim    (victim),
        .wc        (wc.ctrl)
    );

    cacheWays #(
        .indexWidth  (indexWidth),
        .offsetWidth (offsetWidth)
    ) u_ways (
        .clk      (clk),
        .rstn     (rstn),
        .bufIndex (bufIndex),
        .bufTag   (bufTag),
        .bufWord  (bufWord),
        .bufWdata (bufWdata),
        .bufWstrb (bufWstrb),
        .memRdata (memRdata),
        .respData (respData),
        .wc       (wc.ways)
    );

    lruTable #(
        .indexWidth (indexWidth)
    ) u_lru (
        .clk      (clk),
        .rstn     (rstn),
        .bufIndex (bufIndex),
        .touch    (touch),
        .touchWay (touchWay),
        .victim   (victim)
    );

endmodule

//--- sim/tbCache.sv
`timescale 1ns/1ps

module tbCache;
    import cachePkg::*;

    localparam int indexW      = 4;
    localparam int offsetW     = 2;
    localparam int sets        = 2 ** indexW;
    localparam int tagW        = 30 - indexW - offsetW;
    localparam int lineW       = DATA_W * (2 ** offsetW);
    localparam int memBytes    = 1024;            // four tags per set
    localparam int randOps     = 300;
    localparam int totalReqs   = randOps + 20;
    localparam int worstCycles = 16;              // lookup plus two memory waits plus bubble
    localparam logic [31:0] seed = 32'h7cc3_1816;

    logic              clk;
    logic              rstn;
    logic              cpuValid;
    logic              cpuReady;
    cacheOp_t          cpuOp;
    logic [31:0]       cpuAddr;
    logic [DATA_W-1:0] cpuWdata;
    logic [STRB_W-1:0] cpuWstrb;
    logic              respValid;
    logic [DATA_W-1:0] respData;
    logic              memReq;
    logic              memWr;
    logic [31:0]       memAddr;
    logic [DATA_W-1:0] memWdata;
    logic [STRB_W-1:0] memWstrb;
    logic              memAddrOk = 1'b0;
    logic              memDataOk = 1'b0;
    logic [lineW-1:0]  memRdata  = '0;

    // memory responder state
    logic [7:0]  memImg [memBytes];
    logic [31:0] memLfsr;
    logic        reqSeen;
    logic        dataPend;
    logic [1:0]  addrCnt;
    logic [1:0]  dataCnt;
    logic [31:0] dataAddr;

    // reference model state
    logic [7:0]        refMem   [memBytes];
    logic [tagW-1:0]   refTag   [WAYS][sets];
    logic              refValid [WAYS][sets];
    logic              refLru   [sets];      // older way per set
    logic [DATA_W-1:0] expQ [$];

    logic [31:0] stimLfsr;
    string       testName = "reset";
    int readReqs   = 0;   // line requests seen by memory
    int memErr     = 0;
    int predMisses = 0;
    int cmpErr     = 0;
    int chkErr     = 0;
    int readBase;
    int predBase;
    int errBase;
    int testsRun;
    int testsBad;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    cacheTop #(
        .indexWidth  (indexW),
        .offsetWidth (offsetW)
    ) u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .cpuValid  (cpuValid),
        .cpuReady  (cpuReady),
        .cpuOp     (cpuOp),
        .cpuAddr   (cpuAddr),
        .cpuWdata  (cpuWdata),
        .cpuWstrb  (cpuWstrb),
        .respValid (respValid),
        .respData  (respData),
        .memReq    (memReq),
        .memWr     (memWr),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memWstrb  (memWstrb),
        .memAddrOk (memAddrOk),
        .memDataOk (memDataOk),
        .memRdata  (memRdata)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [7:0] fillByte(input logic [9:0] a);
        return a[7:0] ^ {4{a[9:8]}} ^ 8'h5a;
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] takeBits(inout logic [31:0] st, input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], st[0]};
            st   = st[0] ? ((st >> 1) ^ 32'hA300_0000) : (st >> 1);
        end
        return bits;
    endfunction

    function automatic logic [DATA_W-1:0] imgWord(input logic [31:0] addr);
        logic [DATA_W-1:0] w;
        for (int b = 0; b < STRB_W; b++) begin
            w[b*8 +: 8] = memImg[addr[9:0] + 10'(b)];
        end
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] refWord(input logic [31:0] addr);
        logic [DATA_W-1:0] w;
        for (int b = 0; b < STRB_W; b++) begin
            w[b*8 +: 8] = refMem[addr[9:0] + 10'(b)];
        end
        return w;
    endfunction

    function automatic logic [lineW-1:0] imgLine(input logic [31:0] addr);
        logic [lineW-1:0] line;
        for (int b = 0; b < lineW / 8; b++) begin
            line[b*8 +: 8] = memImg[addr[9:0] + 10'(b)];
        end
        return line;
    endfunction

    // expected word and hit flag from the model
    function automatic logic [DATA_W-1:0] refAccess(input cacheOp_t op,
            input logic [31:0] addr, input logic [DATA_W-1:0] wdata,
            input logic [STRB_W-1:0] wstrb, output logic hit);
        logic [indexW-1:0] idx;
        logic [tagW-1:0]   tag;
        logic              way;
        idx = addr[2 + offsetW +: indexW];
        tag = addr[31 -: tagW];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (refValid[w][idx] && refTag[w][idx] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        case (op)
            opRead: begin
                if (!hit) begin
                    way = refLru[idx];   // fill the older way
                    refValid[way][idx] = 1'b1;
                    refTag[way][idx]   = tag;
                end
                refLru[idx] = ~way;
            end
            opWrite: begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wstrb[b]) begin
                        refMem[addr[9:0] + 10'(b)] = wdata[b*8 +: 8];
                    end
                end
                if (hit) begin
                    refLru[idx] = ~way;   // miss leaves the set alone
                end
            end
            opInvalidate: begin
                refValid[0][idx] = 1'b0;
                refValid[1][idx] = 1'b0;
            end
            default: begin
            end
        endcase
        // write-through keeps every cached word equal to memory
        return refWord(addr);
    endfunction

    ////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////

    always @(posedge clk or negedge rstn) begin : responder
        logic [31:0] draw;
        if (!rstn) begin
            memAddrOk <= 1'b0;
            memDataOk <= 1'b0;
            reqSeen   <= 1'b0;
            dataPend  <= 1'b0;
            addrCnt   <= 2'd0;
            dataCnt   <= 2'd0;
            dataAddr  <= '0;
            memLfsr = seed;
            for (int a = 0; a < memBytes; a++) begin
                memImg[a[9:0]] = fillByte(a[9:0]);
            end
        end else begin
            memDataOk <= 1'b0;
            if (dataPend) begin
                if (dataCnt == 2'd0) begin
                    memDataOk <= 1'b1;
                    memRdata  <= imgLine(dataAddr);
                    dataPend  <= 1'b0;
                end else begin
                    dataCnt <= dataCnt - 2'd1;
                end
            end
            if (memReq && memAddrOk) begin   // request taken this cycle
                memAddrOk <= 1'b0;
                reqSeen   <= 1'b0;
                if (memWr) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (memWstrb[b]) begin
                            memImg[memAddr[9:0] + 10'(b)] = memWdata[b*8 +: 8];
                        end
                    end
                end else begin
                    readReqs++;
                    if (memAddr[offsetW+1:0] != '0) begin
                        $display("%s: line request at %h is not line aligned",
                                 testName, memAddr);
                        memErr++;
                    end
                    draw = takeBits(memLfsr, 2);
                    dataPend <= 1'b1;
                    dataCnt  <= draw[1:0];
                    dataAddr <= memAddr;
                end
            end else if (memReq) begin
                if (!reqSeen) begin
                    draw = takeBits(memLfsr, 2);
                    reqSeen <= 1'b1;
                    addrCnt <= draw[1:0];
                end else if (addrCnt == 2'd0) begin
                    memAddrOk <= 1'b1;
                end else begin
                    addrCnt <= addrCnt - 2'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    always @(posedge clk) begin : compare
        logic [DATA_W-1:0] expData;
        logic              expHit;
        if (!rstn) begin
            for (int a = 0; a < memBytes; a++) begin
                refMem[a[9:0]] = fillByte(a[9:0]);
            end
            for (int s = 0; s < sets; s++) begin
                refValid[0][s[indexW-1:0]] = 1'b0;
                refValid[1][s[indexW-1:0]] = 1'b0;
                refLru[s[indexW-1:0]]      = 1'b0;
            end
            expQ.delete();
        end else begin
            if (respValid) begin
                if (expQ.size() == 0) begin
                    $display("%s: response with no outstanding read", testName);
                    cmpErr++;
                end else begin
                    expData = expQ.pop_front();
                    if (respData !== expData) begin
                        $display("ERR %s expected %h actual %h", testName, expData, respData);
                        cmpErr++;
                    end
                end
            end
            if (cpuValid && cpuReady) begin   // accepted at this edge
                expData = refAccess(cpuOp, cpuAddr, cpuWdata, cpuWstrb, expHit);
                if (cpuOp == opRead) begin
                    expQ.push_back(expData);
                    if (!expHit) begin
                        predMisses++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic sendReq(input cacheOp_t op, input logic [31:0] addr,
            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
        cpuValid <= 1'b1;
        cpuOp    <= op;
        cpuAddr  <= addr;
        cpuWdata <= wdata;
        cpuWstrb <= wstrb;
        do begin
            @(posedge clk);
        end while (!cpuReady);
        cpuValid <= 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
        end while (u_dut.u_ctrl.state != Idle);
    endtask

    task automatic checkMemWord(input logic [31:0] addr);
        if (imgWord(addr) !== refWord(addr)) begin
            $display("ERR %s mem[%h] expected %h actual %h",
                     testName, addr, refWord(addr), imgWord(addr));
            chkErr++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        errBase  = cmpErr + memErr + chkErr;
        readBase = readReqs;
        predBase = predMisses;
    endtask

    // expReads below zero skips the fixed count
    task automatic endTest(input int expReads);
        int gotReads;
        int predReads;
        int errs;
        drain();
        gotReads  = readReqs - readBase;
        predReads = predMisses - predBase;
        if (gotReads != predReads) begin
            $display("ERR %s read requests expected %0d actual %0d",
                     testName, predReads, gotReads);
            chkErr++;
        end
        if (expReads >= 0 && gotReads != expReads) begin
            $display("ERR %s read requests expected %0d actual %0d",
                     testName, expReads, gotReads);
            chkErr++;
        end
        if (expQ.size() != 0) begin
            $display("%s: %0d reads never got a response", testName, expQ.size());
            chkErr++;
        end
        errs = cmpErr + memErr + chkErr - errBase;
        testsRun++;
        if (errs == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsBad++;
            $display("test %s: %0d errors", testName, errs);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin : main
        logic [31:0]       r;
        logic [31:0]       addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        cacheOp_t          op;
        rstn     = 1'b0;
        cpuValid = 1'b0;
        cpuOp    = opRead;
        cpuAddr  = '0;
        cpuWdata = '0;
        cpuWstrb = '0;
        stimLfsr = seed;
        testsRun = 0;
        testsBad = 0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        startTest("cold_read");
        sendReq(opRead, 32'h0000_0044, '0, '0);
        endTest(1);

        startTest("line_hit");
        sendReq(opRead, 32'h0000_0048, '0, '0);
        sendReq(opRead, 32'h0000_004c, '0, '0);
        endTest(0);

        startTest("write_through");
        sendReq(opWrite, 32'h0000_0044, 32'hdead_beef, 4'b0101);  // hit on bytes 0 and 2
        sendReq(opRead, 32'h0000_0044, '0, '0);
        sendReq(opWrite, 32'h0000_03a8, 32'h1234_5678, 4'b1111);  // cold set
        sendReq(opRead, 32'h0000_03a8, '0, '0);
        drain();
        checkMemWord(32'h0000_0044);
        checkMemWord(32'h0000_03a8);
        endTest(1);

        // three tags in set 5
        startTest("lru_evict");
        sendReq(opRead, 32'h0000_0050, '0, '0);
        sendReq(opRead, 32'h0000_0150, '0, '0);
        sendReq(opRead, 32'h0000_0050, '0, '0);
        sendReq(opRead, 32'h0000_0250, '0, '0);   // evicts 0x150
        sendReq(opRead, 32'h0000_0050, '0, '0);
        sendReq(opRead, 32'h0000_0150, '0, '0);
        endTest(4);

        startTest("invalidate");
        sendReq(opInvalidate, 32'h0000_0050, '0, '0);
        sendReq(opRead, 32'h0000_0050, '0, '0);
        endTest(1);

        startTest("random");
        for (int i = 0; i < randOps; i++) begin
            r    = takeBits(stimLfsr, 3);
            addr = takeBits(stimLfsr, 8) << 2;
            data = takeBits(stimLfsr, 32);
            op   = (r < 5) ? opRead : ((r < 7) ? opWrite : opInvalidate);
            r    = takeBits(stimLfsr, 4);
            strb = r[3:0];
            sendReq(op, addr, data, strb);
        end
        endTest(-1);

        $display("summary: %0d tests, %0d with errors, %0d errors",
                 testsRun, testsBad, cmpErr + memErr + chkErr);
        if (testsBad == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        cacheState_t stuck;
        #((totalReqs * worstCycles + 100) * 10);
        stuck = u_dut.u_ctrl.state;
        $display("timeout in test %s, cache stuck in state %s", testName, stuck.name());
        $display("tests failed");
        $finish;
    end

endmodule

//--- tb.f
source/cachePkg.sv
source/wayCtrlIf.sv
source/lruTable.sv
source/cacheWays.sv
source/cacheCtrl.sv
source/cacheTop.sv
sim/tbCache.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbCache -f tb.f -o simCache || exit 1
./obj_dir/simCache > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
